// File: dv/rvfi_properties.sv
`default_nettype none

module rvfi_properties import rvfi_pkg::*; (
  input wire        clk_i,
  input wire        rst_ni,
  input wire        irq_ack_i,
  input exc_cause_t irq_cause_i,
  input wire        dbg_ack_i,
  input dbg_cause_t dbg_cause_i,
  input wire        wake_i,
  input wire        step_en_i,
  input stage_tag_t if_tag_i,
  input wire        valid_i,
  input rvfi_intr_t intr_i,
  input rvfi_trap_t trap_i,
  input dbg_cause_t dbg_i,
  input wire        sleep_i,
  input wire        wu_i,
  input exc_cause_t mcause_i,
  input dbg_cause_t dcsr_cause_i,
  input wire        core_sleep_i
);

  // Number of failed assertions
  int fail_count = 0;

  // Trap fields of the previous record
  logic       last_exc;
  logic       last_debug;
  logic       last_dbg_none;
  exc_cause_t last_cause;
  // A sleep record is still waiting for its wake-up record
  logic       seen_sleep;
  // Debug acknowledges that have not yet shown up on a record
  int         dbg_pend;
  logic       dbg_inc;
  logic       dbg_dec;

  assign dbg_inc = dbg_ack_i && (dbg_cause_i != DBG_CAUSE_NONE);
  assign dbg_dec = valid_i && (dbg_i != DBG_CAUSE_NONE) && !last_debug && (dbg_pend != 0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_exc      <= 1'b0;
      last_debug    <= 1'b0;
      last_dbg_none <= 1'b1;
      last_cause    <= '0;
      seen_sleep    <= 1'b0;
      dbg_pend      <= 0;
    end else begin
      dbg_pend <= dbg_pend + int'(dbg_inc) - int'(dbg_dec);
      if (valid_i) begin
        last_exc      <= trap_i.exception;
        last_debug    <= trap_i.debug;
        last_dbg_none <= (dbg_i == DBG_CAUSE_NONE);
        last_cause    <= trap_i.exception_cause;
        if (sleep_i) begin
          seen_sleep <= 1'b1;
        end else if (wu_i) begin
          seen_sleep <= 1'b0;
        end
      end
    end
  end

  ////////////////////////////////////////
  // Capture and handler entry
  ////////////////////////////////////////

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_ack_i |=> if_tag_i.intr.intr && (if_tag_i.intr.cause == $past(irq_cause_i)))
    else begin
      fail_count++;
      $error("Interrupt acknowledge not captured in IF tag");
    end

  // The handler entry follows every trapped exception
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_i && last_exc |-> intr_i.intr && intr_i.exception && (intr_i.cause == last_cause))
    else begin
      fail_count++;
      $error("Trap not followed by handler entry");
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_i && last_exc && (!last_debug || last_dbg_none) |-> mcause_i == last_cause)
    else begin
      fail_count++;
      $error("mcause disagrees with trap cause");
    end

  ////////////////////////////////////////
  // Debug and single step
  ////////////////////////////////////////

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_i && (dbg_i != DBG_CAUSE_NONE) && !last_debug |-> dbg_pend != 0)
    else begin
      fail_count++;
      $error("Debug cause without an acknowledge");
    end

  // Exactly the records retired under single step are step debug traps
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_i |-> (trap_i.debug == $past(step_en_i)) &&
                (trap_i.debug_cause == ($past(step_en_i) ? DBG_CAUSE_STEP : DBG_CAUSE_NONE)))
    else begin
      fail_count++;
      $error("Debug trap does not match single step");
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_i && last_debug |-> (dbg_i == DBG_CAUSE_STEP) && (dcsr_cause_i == DBG_CAUSE_STEP))
    else begin
      fail_count++;
      $error("Step trap not followed by step debug entry");
    end

  ////////////////////////////////////////
  // Sleep
  ////////////////////////////////////////

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_i && sleep_i |=> core_sleep_i)
    else begin
      fail_count++;
      $error("Core did not go to sleep after wfi");
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    core_sleep_i && !wake_i |=> core_sleep_i)
    else begin
      fail_count++;
      $error("Core woke up without wake-up");
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    core_sleep_i && wake_i |=> !core_sleep_i)
    else begin
      fail_count++;
      $error("Core stayed asleep after wake-up");
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_i && wu_i |-> seen_sleep)
    else begin
      fail_count++;
      $error("Wake-up record without a sleep record");
    end

endmodule : rvfi_properties

bind rvfi_trace_top rvfi_properties u_props (
  .clk_i, .rst_ni, .irq_ack_i, .irq_cause_i, .dbg_ack_i, .dbg_cause_i, .wake_i, .step_en_i,
  .if_tag_i     (u_stage_pipe.tags_q[0]),
  .valid_i      (rvfi_valid_o),
  .intr_i       (rvfi_intr_o),
  .trap_i       (rvfi_trap_o),
  .dbg_i        (rvfi_dbg_o),
  .sleep_i      (rvfi_sleep_o),
  .wu_i         (rvfi_wu_o),
  .mcause_i     (rvfi_mcause_o),
  .dcsr_cause_i (rvfi_dcsr_cause_o),
  .core_sleep_i (core_sleep_o)
);

`default_nettype wire

// File: dv/tb_rvfi_trace.sv
`default_nettype none

module tb_rvfi_trace import rvfi_pkg::*; ();

  // Reset, directed phases and random phase, plus margin
  localparam int TIMEOUT_CYCLES = 600;

  logic        clk_i = 1'b0;
  logic        rst_ni = 1'b0;
  logic        advance_i = 1'b0;
  logic        fetch_valid_i = 1'b0;
  logic        irq_ack_i = 1'b0;
  logic        dbg_ack_i = 1'b0;
  logic        wb_exc_i = 1'b0;
  logic        wb_wfi_i = 1'b0;
  logic        wake_i = 1'b0;
  logic        step_en_i = 1'b0;
  exc_cause_t  irq_cause_i = '0;
  exc_cause_t  wb_exc_cause_i = '0;
  dbg_cause_t  dbg_cause_i = '0;
  logic        rvfi_valid_o;
  logic        rvfi_sleep_o;
  logic        rvfi_wu_o;
  logic        core_sleep_o;
  rvfi_intr_t  rvfi_intr_o;
  rvfi_trap_t  rvfi_trap_o;
  dbg_cause_t  rvfi_dbg_o;
  dbg_cause_t  rvfi_dcsr_cause_o;
  exc_cause_t  rvfi_mcause_o;

  int          errors = 0;
  int          cycles = 0;
  int          seed = 32'h8b8b;
  logic [31:0] r1;
  logic [31:0] r2;

  rvfi_trace_top u_dut (.*);

  initial begin
    forever #50 clk_i = ~clk_i;
  end

  // Free running cycle count that bounds the run
  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the run did not finish", cycles);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // Inputs change a little after each rising edge
  task automatic cycle();
    @(posedge clk_i);
    #10;
  endtask

  task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (exp == act) else begin
      errors++;
      $display("FAIL %s expected %0h actual %0h", name, exp, act);
    end
  endtask

  // One pipeline advance after which the acknowledges drop again
  task automatic adv(input logic fv, input logic exc, input exc_cause_t cause, input logic wfi);
    advance_i      = 1'b1;
    fetch_valid_i  = fv;
    wb_exc_i       = exc;
    wb_exc_cause_i = cause;
    wb_wfi_i       = wfi;
    cycle();
    {advance_i, fetch_valid_i, wb_exc_i, wb_wfi_i, irq_ack_i, dbg_ack_i} = '0;
  endtask

  task automatic flush();
    repeat (4) adv(1'b0, 1'b0, '0, 1'b0);
  endtask

  task automatic check_low(input string name);
    check_eq(name, 0, {rvfi_valid_o, rvfi_intr_o, rvfi_trap_o, rvfi_dbg_o, rvfi_sleep_o,
                       rvfi_wu_o, rvfi_mcause_o, rvfi_dcsr_cause_o, core_sleep_o});
  endtask

  initial begin
    // Reset state
    repeat (10) begin
      cycle();
      check_low("reset");
    end
    rst_ni = 1'b1;
    cycle();
    check_low("after_reset");

    // Interrupt entry
    flush();
    irq_ack_i   = 1'b1;
    irq_cause_i = 6'd11;
    adv(1'b1, 1'b0, '0, 1'b0);
    repeat (4) adv(1'b0, 1'b0, '0, 1'b0);
    check_eq("irq_valid", 1, rvfi_valid_o);
    check_eq("irq_intr", {1'b1, 1'b0, 6'd11}, rvfi_intr_o);

    // Exception and handler entry
    flush();
    repeat (2) adv(1'b1, 1'b0, '0, 1'b0);
    repeat (2) adv(1'b0, 1'b0, '0, 1'b0);
    adv(1'b0, 1'b1, 6'd2, 1'b0);
    check_eq("exc_trap", 1, rvfi_trap_o.trap && rvfi_trap_o.exception);
    check_eq("exc_cause", 2, rvfi_trap_o.exception_cause);
    adv(1'b0, 1'b0, '0, 1'b0);
    check_eq("handler_intr", {1'b1, 1'b1, 6'd2}, rvfi_intr_o);
    check_eq("handler_mcause", 2, rvfi_mcause_o);

    // Debug halt request
    flush();
    dbg_ack_i   = 1'b1;
    dbg_cause_i = DBG_CAUSE_HALTREQ;
    adv(1'b1, 1'b0, '0, 1'b0);
    repeat (4) adv(1'b0, 1'b0, '0, 1'b0);
    check_eq("halt_dbg", DBG_CAUSE_HALTREQ, rvfi_dbg_o);
    check_eq("halt_dcsr", DBG_CAUSE_HALTREQ, rvfi_dcsr_cause_o);

    // Single step where the second retirement also carries an exception
    flush();
    step_en_i = 1'b1;
    repeat (3) adv(1'b1, 1'b0, '0, 1'b0);
    adv(1'b0, 1'b0, '0, 1'b0);
    adv(1'b0, 1'b0, '0, 1'b0);
    check_eq("step_debug", {1'b1, DBG_CAUSE_STEP}, {rvfi_trap_o.debug, rvfi_trap_o.debug_cause});
    adv(1'b0, 1'b1, 6'd5, 1'b0);
    check_eq("step_dbg", DBG_CAUSE_STEP, rvfi_dbg_o);
    check_eq("step_dcsr", DBG_CAUSE_STEP, rvfi_dcsr_cause_o);
    adv(1'b0, 1'b0, '0, 1'b0);
    check_eq("step_exc_intr", {1'b1, 1'b1, 6'd5}, rvfi_intr_o);
    check_eq("step_exc_mcause", 5, rvfi_mcause_o);
    step_en_i = 1'b0;

    // Sleep and wake-up
    flush();
    adv(1'b1, 1'b0, '0, 1'b0);
    repeat (3) adv(1'b0, 1'b0, '0, 1'b0);
    adv(1'b0, 1'b0, '0, 1'b1);
    check_eq("wfi_sleep", 1, rvfi_valid_o && rvfi_sleep_o);
    cycle();
    check_eq("core_sleep_rise", 1, core_sleep_o);
    repeat (3) cycle();
    wake_i = 1'b1;
    cycle();
    wake_i = 1'b0;
    check_eq("core_sleep_fall", 0, core_sleep_o);
    adv(1'b1, 1'b0, '0, 1'b0);
    repeat (4) adv(1'b0, 1'b0, '0, 1'b0);
    check_eq("wake_wu", 1, rvfi_valid_o && rvfi_wu_o);

    // Random traffic with rare acknowledges, exceptions and wfi
    repeat (300) begin
      r1 = $random(seed);
      r2 = $random(seed);
      irq_cause_i    = r1[13:8];
      dbg_cause_i    = r1[18] ? DBG_CAUSE_HALTREQ : DBG_CAUSE_EBREAK;
      irq_ack_i      = (r1[7:4] == 0);
      dbg_ack_i      = (r1[17:14] == 0);
      step_en_i      = step_en_i ^ (r2[11:6] == 0);
      advance_i      = r1[0];
      fetch_valid_i  = r1[1];
      wb_exc_i       = r1[0] && (r1[21:19] == 0);
      wb_exc_cause_i = r1[27:22];
      wb_wfi_i       = r1[0] && (r2[5:0] == 0);
      cycle();
      if (wb_wfi_i) begin
        // Hold the pipeline until a sleeping core is woken up again
        {advance_i, fetch_valid_i, wb_exc_i, wb_wfi_i, irq_ack_i, dbg_ack_i} = '0;
        if (rvfi_valid_o && rvfi_sleep_o) begin
          repeat (3 + r2[14:12]) cycle();
          wake_i = 1'b1;
          cycle();
          wake_i = 1'b0;
        end
      end
    end
    {advance_i, fetch_valid_i, wb_exc_i, wb_wfi_i, irq_ack_i, dbg_ack_i, step_en_i} = '0;
    repeat (5) cycle();

    $display("Errors: %0d checks, %0d properties", errors, u_dut.u_props.fail_count);
    if (errors == 0 && u_dut.u_props.fail_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule : tb_rvfi_trace

`default_nettype wire

// File: list.f
source/rvfi_pkg.sv
source/rvfi_stage_pipe.sv
source/rvfi_trap_tracker.sv
source/rvfi_sleep_tracker.sv
source/rvfi_trace_top.sv
dv/rvfi_properties.sv
dv/tb_rvfi_trace.sv

// File: source/rvfi_pkg.sv
`default_nettype none

package rvfi_pkg;

  ////////////////////////////////////////
  // Widths and codes
  ////////////////////////////////////////

  // Exception and interrupt cause as seen in mcause[5:0]
  typedef logic [5:0] exc_cause_t;

  // Debug entry cause as seen in dcsr.cause
  typedef logic [2:0] dbg_cause_t;

  // Index into the four-stage side pipeline
  typedef logic [1:0] stage_idx_t;

  localparam dbg_cause_t DBG_CAUSE_NONE    = 3'd0;
  localparam dbg_cause_t DBG_CAUSE_EBREAK  = 3'd1;
  localparam dbg_cause_t DBG_CAUSE_HALTREQ = 3'd3;
  localparam dbg_cause_t DBG_CAUSE_STEP    = 3'd4;

  // Stage numbering follows the core, IF first and WB last
  localparam stage_idx_t STAGE_IF = 2'd0;
  localparam stage_idx_t STAGE_ID = 2'd1;
  localparam stage_idx_t STAGE_EX = 2'd2;
  localparam stage_idx_t STAGE_WB = 2'd3;

  localparam int unsigned NUM_STAGES = 4;

  ////////////////////////////////////////
  // Record fields
  ////////////////////////////////////////

  // Handler entry information for one retired instruction
  typedef struct packed {
    logic       intr;
    logic       exception;
    exc_cause_t cause;
  } rvfi_intr_t;

  // Trap information for one retired instruction
  // The trap bit is the OR of the exception and debug bits
  typedef struct packed {
    logic       trap;
    logic       exception;
    logic       debug;
    exc_cause_t exception_cause;
    dbg_cause_t debug_cause;
  } rvfi_trap_t;

  // Flags that travel with an instruction from fetch to writeback
  typedef struct packed {
    logic       valid;
    rvfi_intr_t intr;
    dbg_cause_t dbg_cause;
  } stage_tag_t;

  ////////////////////////////////////////
  // Sleep tracking
  ////////////////////////////////////////

  typedef enum logic {
    AWAKE,
    ASLEEP
  } sleep_state_e;

endpackage : rvfi_pkg

`default_nettype wire

// File: source/rvfi_sleep_tracker.sv
`default_nettype none

module rvfi_sleep_tracker import rvfi_pkg::*; (
  input  wire  clk_i,
  input  wire  rst_ni,

  input  wire  retire_i,
  input  wire  wb_wfi_i,
  input  wire  wake_i,

  output logic sleep_o,
  output logic wu_o,
  output logic core_sleep_o
);

  sleep_state_e state_q;
  sleep_state_e state_d;

  // Set on wake-up until the next retirement carries the mark
  logic         wu_pend_q;
  logic         core_sleep_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      AWAKE: begin
        if (retire_i && wb_wfi_i) begin
          state_d = ASLEEP;
        end
      end
      ASLEEP: begin
        // Retirements while asleep are a core error and are ignored
        if (wake_i) begin
          state_d = AWAKE;
        end
      end
      default: state_d = AWAKE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= AWAKE;
      wu_pend_q    <= 1'b0;
      core_sleep_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // Rises one cycle after the sleep record and drops right after wake_i
      core_sleep_q <= (state_q == ASLEEP) && !wake_i;
      if ((state_q == ASLEEP) && wake_i) begin
        wu_pend_q <= 1'b1;
      end else if (retire_i) begin
        wu_pend_q <= 1'b0;
      end
    end
  end

  // Only a wfi retiring while awake starts a sleep period
  assign sleep_o      = wb_wfi_i && (state_q == AWAKE);
  assign wu_o         = wu_pend_q;
  assign core_sleep_o = core_sleep_q;

endmodule : rvfi_sleep_tracker

`default_nettype wire

// File: source/rvfi_stage_pipe.sv
`default_nettype none

module rvfi_stage_pipe import rvfi_pkg::*; (
  input  wire        clk_i,
  input  wire        rst_ni,

  // Pipeline movement from the core
  input  wire        advance_i,
  input  wire        fetch_valid_i,

  // Acknowledges that mark the instruction entering IF
  input  wire        irq_ack_i,
  input  exc_cause_t irq_cause_i,
  input  wire        dbg_ack_i,
  input  dbg_cause_t dbg_cause_i,

  output stage_tag_t wb_tag_o,
  output logic       retire_o
);

  ////////////////////////////////////////
  // Tag storage
  ////////////////////////////////////////

  // One tag per pipeline stage, index 0 is IF
  stage_tag_t [NUM_STAGES-1:0] tags_q;
  stage_tag_t [NUM_STAGES-1:0] tags_d;

  // IF tag before the acknowledges are merged in
  stage_tag_t if_base;

  always_comb begin
    // Hold every stage unless the core advances
    tags_d  = tags_q;
    if_base = tags_q[STAGE_IF];

    if (advance_i) begin
      // Each later stage takes the tag of the stage before it
      tags_d[STAGE_WB] = tags_q[STAGE_EX];
      tags_d[STAGE_EX] = tags_q[STAGE_ID];
      tags_d[STAGE_ID] = tags_q[STAGE_IF];

      // A freshly fetched slot starts with clear flags
      if_base       = '0;
      if_base.valid = fetch_valid_i;
    end

    // An interrupt acknowledge marks the next IF instruction as the
    // first instruction of the handler
    if (irq_ack_i) begin
      if_base.intr.intr      = 1'b1;
      if_base.intr.exception = 1'b0;
      if_base.intr.cause     = irq_cause_i;
    end

    // A debug acknowledge is recorded independently of the interrupt,
    // so both survive when they arrive together
    if (dbg_ack_i) begin
      if_base.dbg_cause = dbg_cause_i;
    end

    tags_d[STAGE_IF] = if_base;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tags_q <= '0;
    end else begin
      tags_q <= tags_d;
    end
  end

  ////////////////////////////////////////
  // Retirement
  ////////////////////////////////////////

  // The WB instruction leaves the pipeline when the core advances
  assign retire_o = advance_i && tags_q[STAGE_WB].valid;

  // Trackers read the WB tag during the retiring cycle
  assign wb_tag_o = tags_q[STAGE_WB];

endmodule : rvfi_stage_pipe

`default_nettype wire

// File: source/rvfi_trace_top.sv
`default_nettype none

module rvfi_trace_top import rvfi_pkg::*; (
  input  wire        clk_i,
  input  wire        rst_ni,

  input  wire        advance_i,
  input  wire        fetch_valid_i,
  input  wire        irq_ack_i,
  input  exc_cause_t irq_cause_i,
  input  wire        dbg_ack_i,
  input  dbg_cause_t dbg_cause_i,
  input  wire        wb_exc_i,
  input  exc_cause_t wb_exc_cause_i,
  input  wire        wb_wfi_i,
  input  wire        wake_i,
  input  wire        step_en_i,

  output logic       rvfi_valid_o,
  output rvfi_intr_t rvfi_intr_o,
  output rvfi_trap_t rvfi_trap_o,
  output dbg_cause_t rvfi_dbg_o,
  output logic       rvfi_sleep_o,
  output logic       rvfi_wu_o,
  output exc_cause_t rvfi_mcause_o,
  output dbg_cause_t rvfi_dcsr_cause_o,
  output logic       core_sleep_o
);

  // One retired instruction as it leaves the unit
  typedef struct packed {
    rvfi_intr_t intr;
    rvfi_trap_t trap;
    dbg_cause_t dbg;
    logic       sleep;
    logic       wu;
    exc_cause_t mcause;
    dbg_cause_t dcsr_cause;
  } trace_rec_t;

  stage_tag_t wb_tag;
  logic       retire;
  trace_rec_t rec_d;
  trace_rec_t rec_q;
  logic       valid_q;

  ////////////////////////////////////////
  // Blocks
  ////////////////////////////////////////

  rvfi_stage_pipe u_stage_pipe (
    .clk_i, .rst_ni, .advance_i, .fetch_valid_i,
    .irq_ack_i, .irq_cause_i, .dbg_ack_i, .dbg_cause_i,
    .wb_tag_o (wb_tag),
    .retire_o (retire)
  );

  rvfi_trap_tracker u_trap_tracker (
    .clk_i, .rst_ni,
    .retire_i       (retire),
    .wb_tag_i       (wb_tag),
    .wb_exc_i, .wb_exc_cause_i, .step_en_i,
    .trap_o         (rec_d.trap),
    .intr_o         (rec_d.intr),
    .dbg_o          (rec_d.dbg),
    .mcause_o       (rec_d.mcause),
    .dcsr_cause_o   (rec_d.dcsr_cause)
  );

  // core_sleep_o leaves the tracker already registered
  rvfi_sleep_tracker u_sleep_tracker (
    .clk_i, .rst_ni,
    .retire_i     (retire),
    .wb_wfi_i, .wake_i,
    .sleep_o      (rec_d.sleep),
    .wu_o         (rec_d.wu),
    .core_sleep_o
  );

  ////////////////////////////////////////
  // Output record
  ////////////////////////////////////////

  // Fields hold between retirements, only the valid bit drops
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      rec_q   <= '0;
    end else begin
      valid_q <= retire;
      if (retire) begin
        rec_q <= rec_d;
      end
    end
  end

  assign rvfi_valid_o      = valid_q;
  assign rvfi_intr_o       = rec_q.intr;
  assign rvfi_trap_o       = rec_q.trap;
  assign rvfi_dbg_o        = rec_q.dbg;
  assign rvfi_sleep_o      = rec_q.sleep;
  assign rvfi_wu_o         = rec_q.wu;
  assign rvfi_mcause_o     = rec_q.mcause;
  assign rvfi_dcsr_cause_o = rec_q.dcsr_cause;

endmodule : rvfi_trace_top

`default_nettype wire

// File: source/rvfi_trap_tracker.sv
`default_nettype none

module rvfi_trap_tracker import rvfi_pkg::*; (
  input  wire        clk_i,
  input  wire        rst_ni,

  input  wire        retire_i,
  input  stage_tag_t wb_tag_i,
  input  wire        wb_exc_i,
  input  exc_cause_t wb_exc_cause_i,
  input  wire        step_en_i,

  output rvfi_trap_t trap_o,
  output rvfi_intr_t intr_o,
  output dbg_cause_t dbg_o,
  output exc_cause_t mcause_o,
  output dbg_cause_t dcsr_cause_o
);

  // Trap field of the previous retired instruction
  rvfi_trap_t trap_q;
  exc_cause_t mcause_q;
  dbg_cause_t dcsr_cause_q;

  // The retiring instruction entered debug through an acknowledge
  logic       dbg_entry;
  logic       mcause_we;

  ////////////////////////////////////////
  // Fields of the retiring instruction
  ////////////////////////////////////////

  always_comb begin
    trap_o = '0;
    if (wb_exc_i) begin
      trap_o.exception       = 1'b1;
      trap_o.exception_cause = wb_exc_cause_i;
    end
    // Single step traps every instruction into debug
    if (step_en_i) begin
      trap_o.debug       = 1'b1;
      trap_o.debug_cause = DBG_CAUSE_STEP;
    end
    trap_o.trap = trap_o.exception || trap_o.debug;
  end

  // After an exception the next retirement is the handler entry, which
  // takes precedence over anything captured in the tag
  always_comb begin
    intr_o = wb_tag_i.intr;
    if (trap_q.exception) begin
      intr_o.intr      = 1'b1;
      intr_o.exception = 1'b1;
      intr_o.cause     = trap_q.exception_cause;
    end
  end

  // A debug trap on the previous instruction means step entry here
  assign dbg_o = trap_q.debug ? trap_q.debug_cause : wb_tag_i.dbg_cause;

  ////////////////////////////////////////
  // CSR mirrors
  ////////////////////////////////////////

  assign dbg_entry = (wb_tag_i.dbg_cause != DBG_CAUSE_NONE);

  // mcause is left alone when the trap goes into debug mode
  assign mcause_we = retire_i && trap_o.exception && !(step_en_i && dbg_entry);

  assign mcause_o = mcause_q;

  // The debug entering instruction already sees the new dcsr cause
  assign dcsr_cause_o = (dbg_o != DBG_CAUSE_NONE) ? dbg_o : dcsr_cause_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      trap_q       <= '0;
      mcause_q     <= '0;
      dcsr_cause_q <= DBG_CAUSE_NONE;
    end else if (retire_i) begin
      trap_q <= trap_o;
      if (mcause_we) begin
        mcause_q <= wb_exc_cause_i;
      end
      if (dbg_o != DBG_CAUSE_NONE) begin
        dcsr_cause_q <= dbg_o;
      end
    end
  end

endmodule : rvfi_trap_tracker

`default_nettype wire
